// File: hdl/request_consts.svh
`ifndef REQUEST_CONSTS_SVH
`define REQUEST_CONSTS_SVH

// Request sources feeding the cache
`define REQ_NUM_REQUESTORS 4

// Payload field widths
`define REQ_ID_W   4
`define REQ_ADDR_W 32

// Per-requestor input queue
`define REQ_IN_FIFO_DEPTH  16
`define REQ_IN_PROG_THRESH 12

// Merged output queue toward the memory port
`define REQ_OUT_FIFO_DEPTH  32
`define REQ_OUT_PROG_THRESH 16

`endif

// File: hdl/request_pkg.sv
`default_nettype none

`include "request_consts.svh"

package request_pkg;

  // --------------------------------------------------
  // Request command encoding
  // --------------------------------------------------
  typedef enum logic [1:0] {
    CMD_READ_VERTEX    = 2'b00,
    CMD_READ_EDGE      = 2'b01,
    CMD_WRITE_PROPERTY = 2'b10,
    CMD_NOP            = 2'b11
  } req_cmd_t;

  // --------------------------------------------------
  // Request payload, 54 bits packed
  // --------------------------------------------------
  typedef struct packed {
    // What the memory port should do
    req_cmd_t                   cmd;
    // Index of the requestor that issued it
    logic [`REQ_ID_W-1:0]       id;
    // Byte address in graph memory
    logic [`REQ_ADDR_W-1:0]     addr;
    // Number of beats requested
    logic [15:0]                burst_len;
  } request_payload_t;

endpackage : request_pkg

`default_nettype wire

// File: hdl/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int WIDTH       = 54,
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             wr_en,
  input  logic             rd_en,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout,
  output logic             valid,
  output logic             full,
  output logic             empty,
  output logic             prog_full,
  output logic             rst_busy
);

  localparam int ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  logic [WIDTH-1:0]   mem [DEPTH];
  logic [ADDR_W-1:0]  wr_ptr;
  logic [ADDR_W-1:0]  rd_ptr;
  logic [COUNT_W-1:0] count;
  // Cycles left in the post-reset busy window
  logic [1:0]         rst_cnt;
  logic               wr_ok;
  logic               rd_ok;

  // --------------------------------------------------
  // Status flags
  // --------------------------------------------------
  assign rst_busy  = (rst_cnt != 2'd0);
  assign empty     = (count == '0);
  // Full also while busy, so no write lands early
  assign full      = (count == COUNT_W'(DEPTH)) | rst_busy;
  assign prog_full = (count >= COUNT_W'(PROG_THRESH));

  // Accepted operations only
  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & ~empty & ~rst_busy;

  // Busy through reset and two cycles after it
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rst_cnt <= 2'd2;
    end else if (rst_cnt != 2'd0) begin
      rst_cnt <= rst_cnt - 2'd1;
    end
  end

  // --------------------------------------------------
  // Pointer, count and valid strobe
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      if (wr_ok) begin
        // Wrap for any depth
        wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + COUNT_W'(wr_ok) - COUNT_W'(rd_ok);
      // Data out one cycle after the pop
      valid <= rd_ok;
    end
  end

  // Array and read register
  always_ff @(posedge ap_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
    if (rd_ok) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule : sync_fifo

`default_nettype wire

// File: hdl/round_robin_arbiter.sv
`default_nettype none

module round_robin_arbiter import request_pkg::*; #(
  parameter int NUM_REQUESTORS = 4
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic                      hold,
  input  logic [NUM_REQUESTORS-1:0] req,
  input  logic [NUM_REQUESTORS-1:0] bus_valid,
  input  request_payload_t          bus_in [NUM_REQUESTORS-1:0],
  output logic [NUM_REQUESTORS-1:0] grant,
  output logic                      bus_out_valid,
  output request_payload_t          bus_out
);

  localparam int IDX_W = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

  // Next index to look at first
  logic [IDX_W-1:0] pointer;
  logic [IDX_W-1:0] grant_idx;
  logic             found;
  request_payload_t sel_payload;

  // --------------------------------------------------
  // Search from the pointer, wrapping once
  // --------------------------------------------------
  always_comb begin
    int idx;
    found     = 1'b0;
    grant_idx = '0;
    for (int k = 0; k < NUM_REQUESTORS; k++) begin
      idx = int'(pointer) + k;
      if (idx >= NUM_REQUESTORS) begin
        idx = idx - NUM_REQUESTORS;
      end
      if (!found && req[idx]) begin
        found     = 1'b1;
        grant_idx = IDX_W'(idx);
      end
    end
  end

  // One-hot, nothing while held
  assign grant = (found && !hold) ? (NUM_REQUESTORS'(1) << grant_idx) : '0;

  // Pointer moves one past each grant
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pointer <= '0;
    end else if (found && !hold) begin
      pointer <= (grant_idx == IDX_W'(NUM_REQUESTORS - 1)) ? '0 : grant_idx + 1'b1;
    end
  end

  // --------------------------------------------------
  // Bus mux
  // --------------------------------------------------
  // Only last cycle's grantee shows valid
  always_comb begin
    sel_payload = bus_in[0];
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      if (bus_valid[i]) begin
        sel_payload = bus_in[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      bus_out_valid <= 1'b0;
    end else begin
      bus_out_valid <= |bus_valid;
    end
  end

  // Payload register
  always_ff @(posedge ap_clk) begin
    bus_out <= sel_payload;
  end

endmodule : round_robin_arbiter

`default_nettype wire

// File: hdl/request_merge_cache.sv
`default_nettype none

`include "request_consts.svh"

module request_merge_cache import request_pkg::*; #(
  parameter int NUM_REQUESTORS = 4
) (
  input  logic                      ap_clk,
  input  logic                      areset_control,
  input  logic                      out_rd_en,
  input  logic [NUM_REQUESTORS-1:0] in_valid,
  input  request_payload_t          in_payload [NUM_REQUESTORS-1:0],
  output logic [NUM_REQUESTORS-1:0] ready,
  output logic                      out_valid,
  output request_payload_t          out_payload,
  output logic                      out_empty,
  output logic                      out_prog_full,
  output logic                      setup
);

  localparam int PAYLOAD_W = $bits(request_payload_t);

  // --------------------------------------------------
  // Internal signals
  // --------------------------------------------------
  // Local reset copy for FIFOs and arbiter
  logic areset_q;

  // Input side registers
  logic [NUM_REQUESTORS-1:0] in_valid_q;
  request_payload_t          in_payload_q [NUM_REQUESTORS-1:0];

  // Input FIFO ports
  logic [PAYLOAD_W-1:0]      in_dout      [NUM_REQUESTORS-1:0];
  logic [NUM_REQUESTORS-1:0] in_fifo_valid;
  logic [NUM_REQUESTORS-1:0] in_fifo_empty;
  logic [NUM_REQUESTORS-1:0] in_fifo_prog_full;
  logic [NUM_REQUESTORS-1:0] in_fifo_rst_busy;
  logic [NUM_REQUESTORS-1:0] in_pop;

  // Arbiter ports
  logic [NUM_REQUESTORS-1:0] arb_grant;
  request_payload_t          arb_bus_in   [NUM_REQUESTORS-1:0];
  logic                      arb_out_valid;
  request_payload_t          arb_out;
  logic                      arb_hold;

  // Merge stage into output FIFO
  logic                      merge_valid;
  request_payload_t          merge_payload;

  // Output FIFO ports
  logic [PAYLOAD_W-1:0]      out_dout;
  logic                      out_fifo_valid;
  logic                      out_fifo_empty;
  logic                      out_fifo_prog_full;
  logic                      out_fifo_rst_busy;
  logic                      out_pop;

  // Some FIFO still in its busy window
  logic                      busy_any;

  always_ff @(posedge ap_clk) begin
    areset_q <= areset_control;
  end

  // --------------------------------------------------
  // Input registers
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_q <= '0;
    end else begin
      in_valid_q <= in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      in_payload_q[i] <= in_payload[i];
    end
  end

  // --------------------------------------------------
  // Per-requestor input FIFOs
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_REQUESTORS; i++) begin : g_in_fifo
    // Pop only a granted, nonempty queue
    assign in_pop[i]     = arb_grant[i] & ~in_fifo_empty[i];
    assign arb_bus_in[i] = request_payload_t'(in_dout[i]);

    sync_fifo #(
      .WIDTH       (PAYLOAD_W),
      .DEPTH       (`REQ_IN_FIFO_DEPTH),
      .PROG_THRESH (`REQ_IN_PROG_THRESH)
    ) u_in_fifo (
      .ap_clk         (ap_clk),
      .areset_control (areset_q),
      .wr_en          (in_valid_q[i]),
      .rd_en          (in_pop[i]),
      .din            (in_payload_q[i]),
      .dout           (in_dout[i]),
      .valid          (in_fifo_valid[i]),
      .full           (),
      .empty          (in_fifo_empty[i]),
      .prog_full      (in_fifo_prog_full[i]),
      .rst_busy       (in_fifo_rst_busy[i])
    );
  end

  // --------------------------------------------------
  // Arbiter
  // --------------------------------------------------
  // Stop at the output watermark, room left for grants in the pipe
  assign arb_hold = out_fifo_prog_full;

  round_robin_arbiter #(
    .NUM_REQUESTORS (NUM_REQUESTORS)
  ) u_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (areset_q),
    .hold           (arb_hold),
    .req            (~in_fifo_empty),
    .bus_valid      (in_fifo_valid),
    .bus_in         (arb_bus_in),
    .grant          (arb_grant),
    .bus_out_valid  (arb_out_valid),
    .bus_out        (arb_out)
  );

  // Merge register
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      merge_valid <= 1'b0;
    end else begin
      merge_valid <= arb_out_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    merge_payload <= arb_out;
  end

  // --------------------------------------------------
  // Output FIFO
  // --------------------------------------------------
  assign out_pop = out_rd_en & ~out_fifo_empty;

  sync_fifo #(
    .WIDTH       (PAYLOAD_W),
    .DEPTH       (`REQ_OUT_FIFO_DEPTH),
    .PROG_THRESH (`REQ_OUT_PROG_THRESH)
  ) u_out_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_q),
    .wr_en          (merge_valid),
    .rd_en          (out_pop),
    .din            (merge_payload),
    .dout           (out_dout),
    .valid          (out_fifo_valid),
    .full           (),
    .empty          (out_fifo_empty),
    .prog_full      (out_fifo_prog_full),
    .rst_busy       (out_fifo_rst_busy)
  );

  // --------------------------------------------------
  // Ready, setup and output status
  // --------------------------------------------------
  assign busy_any = (|in_fifo_rst_busy) | out_fifo_rst_busy;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready         <= '0;
      setup         <= 1'b1;
      out_valid     <= 1'b0;
      out_empty     <= 1'b1;
      out_prog_full <= 1'b0;
    end else begin
      // Held low too until every FIFO leaves reset
      for (int i = 0; i < NUM_REQUESTORS; i++) begin
        ready[i] <= ~in_fifo_prog_full[i] & ~out_fifo_prog_full & ~busy_any;
      end
      setup         <= busy_any;
      out_valid     <= out_fifo_valid;
      out_empty     <= out_fifo_empty;
      out_prog_full <= out_fifo_prog_full;
    end
  end

  // Output payload register
  always_ff @(posedge ap_clk) begin
    out_payload <= request_payload_t'(out_dout);
  end

endmodule : request_merge_cache

`default_nettype wire

// File: hdl/request_merge_top.sv
`default_nettype none

`include "request_consts.svh"

module request_merge_top import request_pkg::*; (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          out_rd_en,
  // One strobe and payload per requestor
  input  logic [`REQ_NUM_REQUESTORS-1:0] in_valid,
  input  request_payload_t              in_payload [`REQ_NUM_REQUESTORS-1:0],
  // Per-requestor flow control
  output logic [`REQ_NUM_REQUESTORS-1:0] ready,
  // Merged stream toward the memory port
  output logic                          out_valid,
  output request_payload_t              out_payload,
  output logic                          out_empty,
  output logic                          out_prog_full,
  // High while any queue leaves reset
  output logic                          setup
);

  // --------------------------------------------------
  // Merge cache
  // --------------------------------------------------
  request_merge_cache #(
    .NUM_REQUESTORS (`REQ_NUM_REQUESTORS)
  ) u_request_merge_cache (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .out_rd_en      (out_rd_en),
    .in_valid       (in_valid),
    .in_payload     (in_payload),
    .ready          (ready),
    .out_valid      (out_valid),
    .out_payload    (out_payload),
    .out_empty      (out_empty),
    .out_prog_full  (out_prog_full),
    .setup          (setup)
  );

endmodule : request_merge_top

`default_nettype wire

// File: testbench/request_merge_tb.sv
`default_nettype none

`include "request_consts.svh"

module request_merge_tb import request_pkg::*; ();

  localparam int N             = `REQ_NUM_REQUESTORS;
  localparam int NUM_TESTS     = 5;
  localparam int READY_TIMEOUT = 50;
  localparam int PUSH_TIMEOUT  = 300;
  localparam int DRAIN_TIMEOUT = 500;
  localparam logic [31:0] SEED = 32'h903aef8e;

  typedef enum int {
    KIND_RESET,
    KIND_DELIVER,
    KIND_ROTATE,
    KIND_BACKPRESSURE
  } outcome_t;

  // --------------------------------------------------
  // Stimulus table, one row per test
  // --------------------------------------------------
  string        tbl_name    [NUM_TESTS] = '{"reset_state", "single_stream", "all_sources",
                                            "rotation", "back_pressure"};
  logic [N-1:0] tbl_mask    [NUM_TESTS] = '{4'b0000, 4'b0100, 4'b1111, 4'b1111, 4'b1111};
  int           tbl_count   [NUM_TESTS] = '{0, 10, 6, 3, 24};
  // Keep the consumer idle while pushing
  bit           tbl_hold_rd [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
  outcome_t     tbl_kind    [NUM_TESTS] = '{KIND_RESET, KIND_DELIVER, KIND_DELIVER,
                                            KIND_ROTATE, KIND_BACKPRESSURE};

  // DUT ports
  logic             ap_clk;
  logic             areset_control;
  logic             out_rd_en;
  logic [N-1:0]     in_valid;
  request_payload_t in_payload [N-1:0];
  logic [N-1:0]     ready;
  logic             out_valid;
  request_payload_t out_payload;
  logic             out_empty;
  logic             out_prog_full;
  logic             setup;

  // Expected packets per source
  request_payload_t exp_q [N][$];
  int               rx_count;
  bit               rotate_mode;
  int               error_count;
  int               pass_count;
  int               fail_count;

  initial ap_clk = 1'b0;
  always #50 ap_clk = ~ap_clk;

  request_merge_top u_request_merge_top (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .out_rd_en      (out_rd_en),
    .in_valid       (in_valid),
    .in_payload     (in_payload),
    .ready          (ready),
    .out_valid      (out_valid),
    .out_payload    (out_payload),
    .out_empty      (out_empty),
    .out_prog_full  (out_prog_full),
    .setup          (setup)
  );

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_payload(input string name, input request_payload_t got,
                               input request_payload_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%014h expected 0x%014h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_mask(input string name, input logic [N-1:0] got,
                            input logic [N-1:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    error_count++;
  endtask

  // Random address and burst with the source index as id
  function automatic request_payload_t make_payload(input int src, input int seq);
    request_payload_t p;
    p.cmd       = req_cmd_t'(2'(seq));
    p.id        = `REQ_ID_W'(src);
    p.addr      = $urandom();
    p.burst_len = 16'($urandom() % 256 + 1);
    return p;
  endfunction

  // Reset held 8 cycles with inputs idle
  task automatic apply_reset();
    @(negedge ap_clk);
    areset_control = 1'b1;
    in_valid       = '0;
    out_rd_en      = 1'b0;
    foreach (exp_q[i]) begin
      exp_q[i].delete();
    end
    rx_count = 0;
    repeat (8) @(negedge ap_clk);
    areset_control = 1'b0;
  endtask

  // Setup low and every source ready
  task automatic wait_for_ready(input string what);
    int cycles;
    cycles = 0;
    while (!(setup === 1'b0 && ready === '1) && cycles < READY_TIMEOUT) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (!(setup === 1'b0 && ready === '1)) begin
      note_failure($sformatf("timed out waiting for setup low and all ready after %s", what));
    end
  endtask

  // Match one output strobe against the expected queues
  task automatic collect_output();
    int               src;
    request_payload_t exp;
    if (out_valid === 1'b1) begin
      // Rotation fixes the source order
      // Otherwise the id picks the queue
      src = rotate_mode ? (rx_count % N) : int'(out_payload.id);
      if (src >= N || exp_q[src].size() == 0) begin
        note_failure($sformatf("unexpected packet with id %0d", out_payload.id));
      end else begin
        exp = exp_q[src].pop_front();
        check_payload("out_payload", out_payload, exp);
      end
      rx_count++;
    end
  endtask

  // --------------------------------------------------
  // Push, then drain and check
  // --------------------------------------------------
  task automatic run_stream(input logic [N-1:0] mask, input int count, input bit hold_rd,
                            input outcome_t kind);
    int               sent [N];
    int               total;
    int               cycles;
    bit               done;
    bit               saw_full;
    request_payload_t p;
    total       = 0;
    cycles      = 0;
    done        = 1'b0;
    saw_full    = 1'b0;
    rotate_mode = (kind == KIND_ROTATE);
    foreach (sent[i]) begin
      sent[i] = 0;
    end
    while (!done && cycles < PUSH_TIMEOUT) begin
      @(negedge ap_clk);
      cycles++;
      collect_output();
      out_rd_en = ~hold_rd;
      done      = 1'b1;
      for (int i = 0; i < N; i++) begin
        in_valid[i] = 1'b0;
        if (mask[i] && sent[i] < count) begin
          done = 1'b0;
          // Only push while the source is ready
          if (ready[i] === 1'b1) begin
            p             = make_payload(i, sent[i]);
            in_payload[i] = p;
            in_valid[i]   = 1'b1;
            exp_q[i].push_back(p);
            sent[i]++;
            total++;
          end
        end
      end
      if (kind == KIND_BACKPRESSURE && out_prog_full === 1'b1 && ready === '0) begin
        saw_full = 1'b1;
        done     = 1'b1;
      end
    end
    in_valid = '0;
    if (!done) begin
      note_failure("timed out pushing packets");
    end
    if (kind == KIND_BACKPRESSURE && !saw_full) begin
      note_failure("ready never fell under back-pressure");
    end
    // Drain everything accepted
    cycles = 0;
    while (rx_count < total && cycles < DRAIN_TIMEOUT) begin
      @(negedge ap_clk);
      cycles++;
      out_rd_en = 1'b1;
      collect_output();
    end
    if (rx_count < total) begin
      note_failure($sformatf("timed out waiting for %0d packets, got %0d", total, rx_count));
    end
    // Any extra strobe now is a duplicate
    repeat (10) begin
      @(negedge ap_clk);
      collect_output();
    end
    foreach (exp_q[i]) begin
      if (exp_q[i].size() != 0) begin
        note_failure($sformatf("source %0d has %0d packets never delivered", i,
                               exp_q[i].size()));
      end
    end
    check_level("out_empty", out_empty, 1'b1);
    if (kind == KIND_BACKPRESSURE) begin
      wait_for_ready("drain");
      check_level("out_prog_full", out_prog_full, 1'b0);
    end
  endtask

  task automatic run_test(input int idx);
    int errors_before;
    errors_before = error_count;
    apply_reset();
    if (tbl_kind[idx] == KIND_RESET) begin
      check_level("out_valid", out_valid, 1'b0);
      check_level("setup", setup, 1'b1);
      check_mask("ready", ready, '0);
      wait_for_ready("reset");
      check_level("out_empty", out_empty, 1'b1);
      check_level("out_prog_full", out_prog_full, 1'b0);
    end else begin
      wait_for_ready("reset");
      run_stream(tbl_mask[idx], tbl_count[idx], tbl_hold_rd[idx], tbl_kind[idx]);
    end
    if (error_count == errors_before) begin
      pass_count++;
      $display("test %s passed", tbl_name[idx]);
    end else begin
      fail_count++;
      $display("test %s failed with %0d errors", tbl_name[idx], error_count - errors_before);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    areset_control = 1'b1;
    out_rd_en      = 1'b0;
    in_valid       = '0;
    for (int i = 0; i < N; i++) begin
      in_payload[i] = '0;
    end
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    rx_count    = 0;
    rotate_mode = 1'b0;
    void'($urandom(SEED));
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests passed %0d, tests failed %0d, errors %0d", pass_count, fail_count,
             error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : request_merge_tb

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/request_pkg.sv
hdl/sync_fifo.sv
hdl/round_robin_arbiter.sv
hdl/request_merge_cache.sv
hdl/request_merge_top.sv
testbench/request_merge_tb.sv

// File: Bender.yml
package:
  name: request_merge_cache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/request_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/round_robin_arbiter.sv
      - hdl/request_merge_cache.sv
      - hdl/request_merge_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/request_merge_tb.sv
